// File: all.f
+incdir+include
hdl/exec_pkg.sv
hdl/muldiv_issue.sv
hdl/alu.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/hilo_reg.sv
hdl/exec_top.sv
verification/tb_exec_top.sv

// File: Bender.yml
package:
  name: exec_stage

export_include_dirs:
  - include

sources:
  - files:
      - hdl/exec_pkg.sv
      - hdl/muldiv_issue.sv
      - hdl/alu.sv
      - hdl/mul_unit.sv
      - hdl/div_unit.sv
      - hdl/hilo_reg.sv
      - hdl/exec_top.sv
  - target: test
    files:
      - verification/tb_exec_top.sv

// File: verification/tb_exec_top.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module tb_exec_top;
    import exec_pkg::*;

    localparam int Period = 100;
    localparam int NumAlu = 40;
    localparam int NumMd  = 30;  // upper bound on multiply/divide runs
    localparam int Budget = 10 + NumAlu + 40 + NumMd * (`EXEC_DIV_CYCLES + 4);

    logic     clk;
    logic     rst_n;
    logic     flush_master;
    logic     flush_slave;
    logic     flush_ex;
    exec_op_e op1;
    exec_op_e op2;
    word_t    src1a, src1b;
    word_t    src2a, src2b;
    shamt_t   shamt1, shamt2;
    word_t    result1, result2;
    logic     ovf1, ovf2;
    logic     stall;

    word_t    exp_res1, exp_res2;
    logic     exp_ovf1, exp_ovf2;
    logic     chk1, chk2, chk_idle;
    dword_t   shadow;  // hi/lo as the rules predict
    int       errors;

    exec_top dut_i (
        .clk_i (clk), .rst_n_i (rst_n),
        .flush_master_i (flush_master), .flush_slave_i (flush_slave), .flush_ex_i (flush_ex),
        .op1_i (op1), .op2_i (op2),
        .src1a_i (src1a), .src1b_i (src1b), .src2a_i (src2a), .src2b_i (src2b),
        .shamt1_i (shamt1), .shamt2_i (shamt2),
        .result1_o (result1), .result2_o (result2),
        .overflow1_o (ovf1), .overflow2_o (ovf2), .stall_o (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    slot1_a: assert property (@(posedge clk) disable iff (!rst_n)
        chk1 |-> (result1 == exp_res1 && ovf1 == exp_ovf1))
        else begin
            errors++;
            $display("ERROR %0t: slot 1 gave %h ovf %b, expected %h ovf %b",
                     $time, $sampled(result1), $sampled(ovf1), exp_res1, exp_ovf1);
        end

    slot2_a: assert property (@(posedge clk) disable iff (!rst_n)
        chk2 |-> (result2 == exp_res2 && ovf2 == exp_ovf2))
        else begin
            errors++;
            $display("ERROR %0t: slot 2 gave %h ovf %b, expected %h ovf %b",
                     $time, $sampled(result2), $sampled(ovf2), exp_res2, exp_ovf2);
        end

    no_stall_a: assert property (@(posedge clk) disable iff (!rst_n) chk_idle |-> !stall)
        else begin
            errors++;
            $display("ERROR %0t: stall high for a single-cycle operation", $time);
        end

    function automatic exec_op_e pick_alu_op();
        return exec_op_e'($urandom_range(1, 15));  // add .. mflo
    endfunction

    function automatic word_t alu_ref(input exec_op_e op, input word_t a, input word_t b,
                                      input shamt_t sh, output logic ovf);
        longint wide;
        ovf = 1'b0;
        case (op)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                if (op == OP_ADD || op == OP_ADDU)
                    wide = longint'($signed(a)) + longint'($signed(b));
                else
                    wide = longint'($signed(a)) - longint'($signed(b));
                // out of 32-bit signed range
                ovf = (op == OP_ADD || op == OP_SUB)
                    && (wide != longint'($signed(word_t'(wide))));
                return word_t'(wide);
            end
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_NOR:  return ~(a | b);
            OP_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            OP_SLTU: return (a < b) ? 1 : 0;
            OP_SLL:  return b << sh;
            OP_SRL:  return b >> sh;
            OP_SRA:  return word_t'({{`EXEC_XLEN{b[`EXEC_XLEN-1]}}, b} >> sh);
            OP_MFHI: return shadow[2*`EXEC_XLEN-1:`EXEC_XLEN];
            OP_MFLO: return shadow[`EXEC_XLEN-1:0];
            default: return '0;
        endcase
    endfunction

    function automatic dword_t hilo_next(input exec_op_e op, input word_t a, input word_t b);
        dword_t sp;
        dword_t up;
        sp = dword_t'(longint'($signed(a)) * longint'($signed(b)));
        up = {word_t'(0), a} * {word_t'(0), b};
        case (op)
            OP_MULT:  return sp;
            OP_MULTU: return up;
            OP_DIV:   return {word_t'(longint'($signed(a)) % longint'($signed(b))),
                              word_t'(longint'($signed(a)) / longint'($signed(b)))};
            OP_DIVU:  return {a % b, a / b};
            OP_MADD:  return shadow + sp;
            OP_MADDU: return shadow + up;
            OP_MSUB:  return shadow - sp;
            OP_MSUBU: return shadow - up;
            OP_MTHI:  return {a, shadow[`EXEC_XLEN-1:0]};
            OP_MTLO:  return {shadow[2*`EXEC_XLEN-1:`EXEC_XLEN], a};
            default:  return shadow;
        endcase
    endfunction

    // one single-cycle pair, checked at the next edge
    task automatic drive_pair(input exec_op_e o1, input word_t a1, input word_t b1,
                              input exec_op_e o2, input word_t a2, input word_t b2);
        @(posedge clk);
        #5;
        op1 = o1; src1a = a1; src1b = b1; shamt1 = shamt_t'($urandom);
        op2 = o2; src2a = a2; src2b = b2; shamt2 = shamt_t'($urandom);
        flush_ex = 1'b0;
        exp_res1 = alu_ref(o1, a1, b1, shamt1, exp_ovf1);
        exp_res2 = alu_ref(o2, a2, b2, shamt2, exp_ovf2);
        chk1 = 1'b1;
        chk2 = 1'b1;
        chk_idle = 1'b1;
        if (o1 inside {OP_MTHI, OP_MTLO})
            shadow = hilo_next(o1, a1, b1);
    endtask

    task automatic read_hilo();
        drive_pair(OP_MFHI, '0, '0, OP_MFLO, '0, '0);
    endtask

    // presents a multiply/divide and waits for stall to drop
    task automatic run_md(input exec_op_e o1, input word_t a1, input word_t b1,
                          input exec_op_e o2, input word_t a2, input word_t b2,
                          input int cycles, input logic fx);
        int       cnt;
        exec_op_e own_op;
        word_t    own_a;
        word_t    own_b;
        @(posedge clk);
        #5;
        op1 = o1; src1a = a1; src1b = b1;
        op2 = o2; src2a = a2; src2b = b2;
        flush_ex = fx;
        chk1 = 1'b0;
        chk2 = 1'b0;
        chk_idle = 1'b0;
        own_op = (o1 == OP_NOP) ? o2 : o1;  // master first
        own_a  = (o1 == OP_NOP) ? a2 : a1;
        own_b  = (o1 == OP_NOP) ? b2 : b1;
        cnt = 0;
        @(negedge clk);
        while (stall && cnt < `EXEC_DIV_CYCLES + 8) begin
            cnt++;
            @(negedge clk);
        end
        stall_len_a: assert (cnt == cycles)
            else begin
                errors++;
                $display("ERROR %0t: stall lasted %0d cycles, expected %0d", $time, cnt, cycles);
            end
        if (o1 == OP_MUL) begin  // low word in the ready cycle
            exp_res1 = word_t'(longint'($signed(a1)) * longint'($signed(b1)));
            exp_ovf1 = 1'b0;
            chk1 = 1'b1;
        end
        if (!fx)
            shadow = hilo_next(own_op, own_a, own_b);
    endtask

    task automatic abort_div(input word_t a, input word_t b);
        @(posedge clk);
        #5;
        op1 = OP_DIV; src1a = a; src1b = b; op2 = OP_NOP;
        chk1 = 1'b0;
        chk2 = 1'b0;
        chk_idle = 1'b0;
        repeat (5) @(posedge clk);
        #5 flush_master = 1'b1;
        @(posedge clk);
        #5;
        op1 = OP_NOP;
        flush_master = 1'b0;
    endtask

    initial begin
        #(Budget * Period);
        $display("timeout: the DUT stopped making progress");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int          i;
        word_t       d;
        void'($urandom(32'h9297_754b));
        errors = 0; shadow = '0;
        chk1 = 1'b0; chk2 = 1'b0; chk_idle = 1'b0;
        flush_master = 1'b0; flush_slave = 1'b0; flush_ex = 1'b0;
        op1 = OP_NOP; op2 = OP_NOP; shamt1 = '0; shamt2 = '0;
        src1a = '0; src1b = '0; src2a = '0; src2b = '0;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #5 rst_n = 1'b1;
        read_hilo();  // zero after reset
        for (i = 0; i < NumAlu; i++)
            drive_pair(pick_alu_op(), $urandom, $urandom, pick_alu_op(), $urandom, $urandom);
        for (i = 0; i < 4; i++) begin
            run_md(i[0] ? OP_MULTU : OP_MULT, $urandom, $urandom, OP_NOP, '0, '0,
                   `EXEC_MUL_CYCLES, 1'b0);
            read_hilo();
            run_md(OP_MUL, $urandom, $urandom, OP_NOP, '0, '0, `EXEC_MUL_CYCLES, 1'b0);
        end
        for (i = 0; i < 4; i++) begin
            d = (i < 2) ? word_t'($urandom) : word_t'($urandom_range(0, 4000) - 2000);
            if (d == '0)
                d = 7;
            run_md(i[0] ? OP_DIVU : OP_DIV, $urandom, d, OP_NOP, '0, '0,
                   `EXEC_DIV_CYCLES + 1, 1'b0);
            read_hilo();
        end
        drive_pair(OP_MTHI, $urandom, '0, OP_NOP, '0, '0);
        drive_pair(OP_MTLO, $urandom, '0, OP_MFHI, '0, '0);
        read_hilo();
        for (i = 0; i < 8; i++) begin
            run_md(exec_op_e'(OP_MADD + (i % 4)), $urandom, $urandom, OP_NOP, '0, '0,
                   `EXEC_MUL_CYCLES, 1'b0);
            if (i[0])
                read_hilo();
        end
        // both slots compete, master owns the unit
        run_md(OP_MULT, $urandom, $urandom, OP_MULTU, $urandom, $urandom,
               `EXEC_MUL_CYCLES, 1'b0);
        read_hilo();
        run_md(OP_DIVU, $urandom, 32'd13, OP_DIV, $urandom, 32'd3, `EXEC_DIV_CYCLES + 1, 1'b0);
        read_hilo();
        run_md(OP_NOP, '0, '0, OP_MULTU, $urandom, $urandom, `EXEC_MUL_CYCLES, 1'b0);
        read_hilo();
        run_md(OP_MULT, $urandom, $urandom, OP_NOP, '0, '0, `EXEC_MUL_CYCLES, 1'b1);
        read_hilo();
        abort_div($urandom, 32'd5);
        read_hilo();
        read_hilo();
        // aborted divider must be idle again, so a new divide runs its full length
        run_md(OP_DIV, $urandom, 32'd11, OP_NOP, '0, '0, `EXEC_DIV_CYCLES + 1, 1'b0);
        read_hilo();
        @(posedge clk);
        #1;
        $display("checks done, errors: %0d", errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: hdl/exec_top.sv
`timescale 1ns/1ps

module exec_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               flush_master_i,
    input  logic               flush_slave_i,
    input  logic               flush_ex_i,
    input  exec_pkg::exec_op_e op1_i,
    input  exec_pkg::exec_op_e op2_i,
    input  exec_pkg::word_t    src1a_i,
    input  exec_pkg::word_t    src1b_i,
    input  exec_pkg::word_t    src2a_i,
    input  exec_pkg::word_t    src2b_i,
    input  exec_pkg::shamt_t   shamt1_i,
    input  exec_pkg::shamt_t   shamt2_i,
    output exec_pkg::word_t    result1_o,
    output exec_pkg::word_t    result2_o,
    output logic               overflow1_o,
    output logic               overflow2_o,
    output logic               stall_o
);
    import exec_pkg::*;

    word_t    md_a;
    word_t    md_b;
    word_t    md_src;
    exec_op_e md_op;
    logic     mul_start;
    logic     div_start;
    logic     md_signed;
    logic     md_flush;
    logic     hilo_we;
    logic     mul_ready;
    logic     div_ready;
    dword_t   product;
    dword_t   quotient_rem;
    dword_t   hilo;

    muldiv_issue issue_i (
        .op1_i, .op2_i, .src1a_i, .src1b_i, .src2a_i, .src2b_i,
        .flush_master_i, .flush_slave_i,
        .mul_ready_i (mul_ready),
        .div_ready_i (div_ready),
        .md_a_o      (md_a),
        .md_b_o      (md_b),
        .md_src_o    (md_src),
        .md_op_o     (md_op),
        .mul_start_o (mul_start),
        .div_start_o (div_start),
        .md_signed_o (md_signed),
        .md_flush_o  (md_flush),
        .hilo_we_o   (hilo_we),
        .stall_o
    );

    alu alu_master (
        .op_i (op1_i), .a_i (src1a_i), .b_i (src1b_i), .shamt_i (shamt1_i),
        .product_i (product), .hilo_i (hilo),
        .result_o (result1_o), .overflow_o (overflow1_o)
    );

    alu alu_slave (
        .op_i (op2_i), .a_i (src2a_i), .b_i (src2b_i), .shamt_i (shamt2_i),
        .product_i (product), .hilo_i (hilo),
        .result_o (result2_o), .overflow_o (overflow2_o)
    );

    mul_unit mul_i (
        .clk_i, .rst_n_i, .flush_i (md_flush), .start_i (mul_start),
        .signed_i (md_signed), .a_i (md_a), .b_i (md_b),
        .ready_o (mul_ready), .product_o (product)
    );

    div_unit div_i (
        .clk_i, .rst_n_i, .flush_i (md_flush), .start_i (div_start),
        .signed_i (md_signed), .a_i (md_a), .b_i (md_b),
        .ready_o (div_ready), .quotient_rem_o (quotient_rem)
    );

    hilo_reg hilo_reg_i (
        .clk_i, .rst_n_i, .we_i (hilo_we), .flush_ex_i,
        .op_i (md_op), .src_i (md_src),
        .product_i (product), .quotient_rem_i (quotient_rem),
        .hilo_o (hilo)
    );

endmodule

// File: hdl/hilo_reg.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module hilo_reg (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               we_i,
    input  logic               flush_ex_i,
    input  exec_pkg::exec_op_e op_i,
    input  exec_pkg::word_t    src_i,
    input  exec_pkg::dword_t   product_i,
    input  exec_pkg::dword_t   quotient_rem_i,
    output exec_pkg::dword_t   hilo_o
);
    import exec_pkg::*;

    dword_t hilo_q;
    dword_t hilo_d;

    always_comb begin
        case (op_i)
            OP_MULT, OP_MULTU: hilo_d = product_i;
            OP_DIV, OP_DIVU:   hilo_d = quotient_rem_i;
            OP_MADD, OP_MADDU: hilo_d = hilo_q + product_i;
            OP_MSUB, OP_MSUBU: hilo_d = hilo_q - product_i;
            OP_MTHI:           hilo_d = {src_i, hilo_q[`EXEC_XLEN-1:0]};
            OP_MTLO:           hilo_d = {hilo_q[2*`EXEC_XLEN-1:`EXEC_XLEN], src_i};
            default:           hilo_d = hilo_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hilo_q <= '0;
        end else if (we_i && !flush_ex_i) begin  // flushed ex keeps old value
            hilo_q <= hilo_d;
        end
    end

    assign hilo_o = hilo_q;

endmodule

// File: hdl/div_unit.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module div_unit (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             flush_i,
    input  logic             start_i,
    input  logic             signed_i,
    input  exec_pkg::word_t  a_i,
    input  exec_pkg::word_t  b_i,
    output logic             ready_o,
    output exec_pkg::dword_t quotient_rem_o
);
    import exec_pkg::*;

    localparam int              Msb     = `EXEC_XLEN - 1;
    localparam int              CntW    = $clog2(`EXEC_DIV_CYCLES);
    localparam logic [CntW-1:0] LastCnt = CntW'(`EXEC_DIV_CYCLES - 1);

    div_state_e          state_q;
    logic [CntW-1:0]     cnt_q;
    word_t               quot_q;
    word_t               rem_q;
    word_t               dvs_q;
    logic                neg_quot_q;
    logic                neg_rem_q;
    logic [`EXEC_XLEN:0] partial;
    logic                fits;

    // shifted remainder picks up the next dividend bit
    assign partial = {rem_q, quot_q[Msb]};
    assign fits    = partial >= {1'b0, dvs_q};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    cnt_q <= '0;
                    if (start_i && !flush_i) begin
                        state_q <= DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (flush_i) begin
                        state_q <= DIV_IDLE;
                    end else if (cnt_q == LastCnt) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: state_q <= DIV_IDLE;  // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == DIV_IDLE) begin
            quot_q     <= (signed_i && a_i[Msb]) ? -a_i : a_i;
            dvs_q      <= (signed_i && b_i[Msb]) ? -b_i : b_i;
            rem_q      <= '0;
            neg_quot_q <= signed_i && (a_i[Msb] ^ b_i[Msb]);
            neg_rem_q  <= signed_i && a_i[Msb];   // remainder follows dividend
        end else if (state_q == DIV_RUN) begin
            quot_q <= {quot_q[Msb-1:0], fits};
            rem_q  <= fits ? (partial[Msb:0] - dvs_q) : partial[Msb:0];
        end
    end

    assign ready_o             = (state_q == DIV_DONE);
    assign quotient_rem_o[Msb:0] = neg_quot_q ? -quot_q : quot_q;
    assign quotient_rem_o[2*`EXEC_XLEN-1:`EXEC_XLEN] = neg_rem_q ? -rem_q : rem_q;

    no_flush_start_in_done_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (state_q == DIV_DONE) |-> !(start_i && flush_i)
    ) else $error("divider start with flush while done");

endmodule

// File: hdl/mul_unit.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module mul_unit (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             flush_i,
    input  logic             start_i,
    input  logic             signed_i,
    input  exec_pkg::word_t  a_i,
    input  exec_pkg::word_t  b_i,
    output logic             ready_o,
    output exec_pkg::dword_t product_o
);
    import exec_pkg::*;

    localparam int Stages = `EXEC_MUL_CYCLES;
    localparam int Msb    = `EXEC_XLEN - 1;

    logic [Stages-1:0]              valid_q;
    logic signed [`EXEC_XLEN:0]     a_q;
    logic signed [`EXEC_XLEN:0]     b_q;
    logic signed [2*`EXEC_XLEN+1:0] full_prod;
    dword_t                         prod_q [1:Stages-1];
    logic                           accept;

    assign accept = start_i && !flush_i && !(|valid_q);  // one op in flight

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[Stages-2:0], accept};
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            a_q <= {signed_i && a_i[Msb], a_i};
            b_q <= {signed_i && b_i[Msb], b_i};
        end
        prod_q[1] <= full_prod[2*`EXEC_XLEN-1:0];
        for (int i = 2; i < Stages; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
    end

    assign full_prod = a_q * b_q;  // 33x33 covers both signednesses
    assign ready_o   = valid_q[Stages-1];
    assign product_o = prod_q[Stages-1];

    ready_after_start_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(ready_o) |-> $past(start_i, Stages)
    ) else $error("multiplier ready without a start");

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module alu (
    input  exec_pkg::exec_op_e op_i,
    input  exec_pkg::word_t    a_i,
    input  exec_pkg::word_t    b_i,
    input  exec_pkg::shamt_t   shamt_i,
    input  exec_pkg::dword_t   product_i,
    input  exec_pkg::dword_t   hilo_i,
    output exec_pkg::word_t    result_o,
    output logic               overflow_o
);
    import exec_pkg::*;

    localparam int Msb = `EXEC_XLEN - 1;

    word_t sum;
    word_t diff;
    logic  sum_ovf;
    logic  diff_ovf;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;

    // result sign differs from what the operands allow
    assign sum_ovf  = (a_i[Msb] == b_i[Msb]) && (sum[Msb] != a_i[Msb]);
    assign diff_ovf = (a_i[Msb] != b_i[Msb]) && (diff[Msb] != a_i[Msb]);

    always_comb begin
        result_o   = '0;
        overflow_o = 1'b0;
        case (op_i)
            OP_ADD: begin
                result_o   = sum;
                overflow_o = sum_ovf;
            end
            OP_SUB: begin
                result_o   = diff;
                overflow_o = diff_ovf;
            end
            OP_ADDU: result_o = sum;
            OP_SUBU: result_o = diff;
            OP_AND:  result_o = a_i & b_i;
            OP_OR:   result_o = a_i | b_i;
            OP_XOR:  result_o = a_i ^ b_i;
            OP_NOR:  result_o = ~(a_i | b_i);
            OP_SLT:  result_o = word_t'($signed(a_i) < $signed(b_i));
            OP_SLTU: result_o = word_t'(a_i < b_i);
            OP_SLL:  result_o = b_i << shamt_i;   // shifts act on rt
            OP_SRL:  result_o = b_i >> shamt_i;
            OP_SRA:  result_o = word_t'($signed(b_i) >>> shamt_i);
            OP_MFHI: result_o = hilo_i[2*`EXEC_XLEN-1:`EXEC_XLEN];
            OP_MFLO: result_o = hilo_i[Msb:0];
            OP_MUL:  result_o = product_i[Msb:0];  // valid in the ready cycle
            default: begin
                result_o = '0;  // hi/lo-only ops
            end
        endcase
    end

endmodule

// File: hdl/muldiv_issue.sv
`timescale 1ns/1ps

module muldiv_issue (
    input  exec_pkg::exec_op_e op1_i,
    input  exec_pkg::exec_op_e op2_i,
    input  exec_pkg::word_t    src1a_i,
    input  exec_pkg::word_t    src1b_i,
    input  exec_pkg::word_t    src2a_i,
    input  exec_pkg::word_t    src2b_i,
    input  logic               flush_master_i,
    input  logic               flush_slave_i,
    input  logic               mul_ready_i,
    input  logic               div_ready_i,
    output exec_pkg::word_t    md_a_o,
    output exec_pkg::word_t    md_b_o,
    output exec_pkg::word_t    md_src_o,
    output exec_pkg::exec_op_e md_op_o,
    output logic               mul_start_o,
    output logic               div_start_o,
    output logic               md_signed_o,
    output logic               md_flush_o,
    output logic               hilo_we_o,
    output logic               stall_o
);
    import exec_pkg::*;

    function automatic logic is_mul(input exec_op_e op);
        return op inside {OP_MUL, OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    endfunction

    function automatic logic uses_md(input exec_op_e op);
        return is_mul(op) || (op inside {OP_DIV, OP_DIVU, OP_MTHI, OP_MTLO});
    endfunction

    logic sel_slave;
    logic op_mul;
    logic op_div;
    logic op_mt;

    assign sel_slave = !uses_md(op1_i) && uses_md(op2_i);  // master wins a tie

    assign md_op_o    = sel_slave ? op2_i : op1_i;
    assign md_a_o     = sel_slave ? src2a_i : src1a_i;
    assign md_b_o     = sel_slave ? src2b_i : src1b_i;
    assign md_src_o   = md_a_o;  // mthi/mtlo source
    assign md_flush_o = sel_slave ? flush_slave_i : flush_master_i;

    assign op_mul = is_mul(md_op_o);
    assign op_div = md_op_o inside {OP_DIV, OP_DIVU};
    assign op_mt  = md_op_o inside {OP_MTHI, OP_MTLO};

    assign md_signed_o = md_op_o inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB, OP_DIV};

    // start held until the unit answers
    assign mul_start_o = op_mul && !mul_ready_i;
    assign div_start_o = op_div && !div_ready_i;
    assign stall_o     = mul_start_o || div_start_o;

    // three-operand mul leaves hi/lo alone
    assign hilo_we_o = (op_mul && mul_ready_i && (md_op_o != OP_MUL))
                     || (op_div && div_ready_i)
                     || op_mt;

    always_comb begin
        one_unit_a: assert final (!(mul_ready_i && div_ready_i))
            else $error("multiplier and divider answered together");
    end

endmodule

// File: hdl/exec_pkg.sv
`include "exec_config.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]   word_t;
    typedef logic [2*`EXEC_XLEN-1:0] dword_t;  // hi in upper half
    typedef logic [4:0]              shamt_t;

    // decoded execute operation
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA,
        OP_MFHI, OP_MFLO, OP_MUL,
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
        OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
        OP_MTHI, OP_MTLO
    } exec_op_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

endpackage

// File: include/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// datapath width
`define EXEC_XLEN 32

// multiplier pipeline depth, at least 2
`define EXEC_MUL_CYCLES 2

// shift-subtract steps of the divider
`define EXEC_DIV_CYCLES 32

`endif
